//--- dvbs2_frame_timing.f
+incdir+hdl
+incdir+tests
hdl/dvbs2_pkg.sv
hdl/apb_mode_regs.sv
hdl/frame_length_lut.sv
hdl/frame_phase_ctrl.sv
hdl/ts_packet_source.sv
hdl/dvbs2_frame_timing_top.sv
tests/tb_dvbs2_frame_timing.sv

//--- hdl/apb_mode_regs.sv
`timescale 1ns/1ns
`include "dvbs2_defines.svh"

module apb_mode_regs (
	input  logic                  sys_clk,
	input  logic                  glb_rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [3:0]            paddr,
	input  logic [31:0]           pwdata,
	input  logic                  frame_start,
	output logic [31:0]           prdata,
	output logic                  pslverr,
	output dvbs2_pkg::mode_word_u mode_word,
	output logic                  run_en
);

	// access phase, zero wait states
	logic        access;
	// offset decodes to a register
	logic        addr_ok;
	logic [31:0] rd_word;
	logic [15:0] frame_cnt;
	// ctrl write that drops run_en, clears the frame count
	logic        stop_wr;

	assign access = psel & penable;
	assign stop_wr = access & pwrite & (paddr == `DVBS2_REG_CTRL) & ~pwdata[0];

	//////////////////////////////////////////////////////////////////////
	// address decode and read mux
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		addr_ok = 1'b1;
		case (paddr)
			`DVBS2_REG_MODE: rd_word = {{(32-`DVBS2_MODE_W){1'b0}}, mode_word};
			`DVBS2_REG_CTRL: rd_word = {31'b0, run_en};
			`DVBS2_REG_FCNT: rd_word = {16'b0, frame_cnt};
			default:         addr_ok = 1'b0;
		endcase
	end

	// read data only in the access cycle of a read
	assign prdata = (access && !pwrite) ? rd_word : '0;

	// unmapped offset, or frame count is read only
	assign pslverr = access & (~addr_ok | (pwrite & (paddr == `DVBS2_REG_FCNT)));

	//////////////////////////////////////////////////////////////////////
	// mode and control registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			mode_word <= '0;
			run_en    <= 1'b0;
		end else if (access && pwrite) begin
			case (paddr)
				`DVBS2_REG_MODE: mode_word <= pwdata[`DVBS2_MODE_W-1:0];
				`DVBS2_REG_CTRL: run_en <= pwdata[0];
				default: ;
			endcase
		end
	end

	// frames since the last stop
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			frame_cnt <= '0;
		end else if (stop_wr) begin
			frame_cnt <= '0;
		end else if (frame_start) begin
			frame_cnt <= frame_cnt + 16'd1;
		end
	end

	// setup phase must come first, penable alone is a broken master
	ap_penable_needs_psel: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		penable |-> psel
	);

endmodule

//--- hdl/dvbs2_defines.svh
`ifndef DVBS2_DEFINES_SVH
`define DVBS2_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// mode word, frame size / pilot / modulation / ldpc rate
`define DVBS2_MODE_W 8
// bch payload length in bytes
`define DVBS2_KBCH_W 13
// pl frame length in fs_en ticks
`define DVBS2_PL_W 16

//////////////////////////////////////////////////////////////////////
// transport stream framing
//////////////////////////////////////////////////////////////////////

`define DVBS2_TS_PKT_LEN 8'd188
`define DVBS2_TS_SYNC 8'h47
// baseband header, taken off the bch payload to get the ts window
`define DVBS2_BBHDR_BYTES 10

//////////////////////////////////////////////////////////////////////
// apb register map, byte offsets
//////////////////////////////////////////////////////////////////////

`define DVBS2_REG_MODE 4'h0
`define DVBS2_REG_CTRL 4'h4
`define DVBS2_REG_FCNT 4'h8

`endif

//--- hdl/dvbs2_frame_timing_top.sv
`timescale 1ns/1ns

module dvbs2_frame_timing_top (
	input  logic        sys_clk,
	input  logic        glb_rst_n,
	// apb slave
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pslverr,
	// symbol rate enable
	input  logic        fs_en,
	// frame timing out
	output logic        frame_start,
	output logic        bb_frame_vld,
	// ts byte stream, no back-pressure
	output logic [7:0]  ts_byte,
	output logic        ts_valid,
	output logic        ts_head
);

	dvbs2_pkg::mode_word_u mode_word;
	logic                  run_en;
	dvbs2_pkg::kbch_len_t  kbch_len;
	dvbs2_pkg::kbch_len_t  ts_len;
	dvbs2_pkg::pl_len_t    pl_len;
	logic                  ts_rd_vld;

	// register block
	apb_mode_regs u_regs (
		.sys_clk     (sys_clk),
		.glb_rst_n   (glb_rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.frame_start (frame_start),
		.prdata      (prdata),
		.pslverr     (pslverr),
		.mode_word   (mode_word),
		.run_en      (run_en)
	);

	// mode word to lengths
	frame_length_lut u_lut (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.mode_word (mode_word),
		.kbch_len  (kbch_len),
		.ts_len    (ts_len),
		.pl_len    (pl_len)
	);

	// frame phase and windows
	frame_phase_ctrl u_phase (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.fs_en        (fs_en),
		.run_en       (run_en),
		.kbch_len     (kbch_len),
		.ts_len       (ts_len),
		.pl_len       (pl_len),
		.frame_start  (frame_start),
		.bb_frame_vld (bb_frame_vld),
		.ts_rd_vld    (ts_rd_vld)
	);

	// packet source behind the ts read window
	ts_packet_source u_ts (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.fs_en     (fs_en),
		.ts_rd_vld (ts_rd_vld),
		.ts_byte   (ts_byte),
		.ts_valid  (ts_valid),
		.ts_head   (ts_head)
	);

endmodule

//--- hdl/dvbs2_pkg.sv
`include "dvbs2_defines.svh"

package dvbs2_pkg;

	// bch payload, bytes per frame
	typedef logic [`DVBS2_KBCH_W-1:0] kbch_len_t;

	// pl frame, fs_en ticks per frame
	typedef logic [`DVBS2_PL_W-1:0] pl_len_t;

	// fec side of the mode word
	// frame size on top, ldpc code index at the bottom
	typedef struct packed {
		logic       frame_short;
		logic [2:0] fec_rsvd;
		logic [3:0] ldpc_code;
	} fec_view_t;

	// pl side of the mode word
	// pl_key = {frame_short, pilot_on, modulation[1:0]}
	typedef struct packed {
		logic [3:0] pl_key;
		logic [3:0] pl_rsvd;
	} pl_view_t;

	// one register word, two decoders look at it differently
	typedef union packed {
		fec_view_t fec_view;
		pl_view_t  pl_view;
	} mode_word_u;

endpackage

//--- hdl/frame_length_lut.sv
`timescale 1ns/1ns
`include "dvbs2_defines.svh"

module frame_length_lut (
	input  logic                  sys_clk,
	input  logic                  glb_rst_n,
	input  dvbs2_pkg::mode_word_u mode_word,
	output dvbs2_pkg::kbch_len_t  kbch_len,
	output dvbs2_pkg::kbch_len_t  ts_len,
	output dvbs2_pkg::pl_len_t    pl_len
);

	dvbs2_pkg::kbch_len_t kbch_nxt;
	dvbs2_pkg::kbch_len_t ts_nxt;
	dvbs2_pkg::pl_len_t   pl_nxt;

	//////////////////////////////////////////////////////////////////////
	// bch payload bytes, keyed by {frame_short, ldpc_code}
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case ({mode_word.fec_view.frame_short, mode_word.fec_view.ldpc_code})
			// normal frames, 64800 bit codeword
			5'h00: kbch_nxt = 13'd2001;
			5'h01: kbch_nxt = 13'd2676;
			5'h02: kbch_nxt = 13'd3216;
			5'h03: kbch_nxt = 13'd4026;
			5'h04: kbch_nxt = 13'd4836;
			5'h05: kbch_nxt = 13'd5380;
			5'h06: kbch_nxt = 13'd6051;
			5'h07: kbch_nxt = 13'd6456;
			5'h08: kbch_nxt = 13'd6730;
			5'h09: kbch_nxt = 13'd7184;
			5'h0a: kbch_nxt = 13'd7274;
			// short frames, 16200 bit codeword
			5'h10: kbch_nxt = 13'd384;
			5'h11: kbch_nxt = 13'd654;
			5'h12: kbch_nxt = 13'd789;
			5'h13: kbch_nxt = 13'd879;
			5'h14: kbch_nxt = 13'd1194;
			5'h15: kbch_nxt = 13'd1329;
			5'h16: kbch_nxt = 13'd1464;
			5'h17: kbch_nxt = 13'd1554;
			5'h18: kbch_nxt = 13'd1644;
			5'h19: kbch_nxt = 13'd1779;
			// no such code, windows stay shut
			default: kbch_nxt = 13'd0;
		endcase
	end

	// ts window is the payload minus the bb header
	assign ts_nxt = (kbch_nxt == '0) ? '0 :
		kbch_nxt - dvbs2_pkg::kbch_len_t'(`DVBS2_BBHDR_BYTES);

	//////////////////////////////////////////////////////////////////////
	// pl frame ticks, keyed by {frame_short, pilot_on, modulation}
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (mode_word.pl_view.pl_key)
			// normal, no pilots: qpsk 8psk 16apsk 32apsk
			4'h0: pl_nxt = 16'd32490;
			4'h1: pl_nxt = 16'd21690;
			4'h2: pl_nxt = 16'd16290;
			4'h3: pl_nxt = 16'd13050;
			// normal, pilots on
			4'h4: pl_nxt = 16'd33282;
			4'h5: pl_nxt = 16'd22194;
			4'h6: pl_nxt = 16'd16686;
			4'h7: pl_nxt = 16'd13338;
			// short, no pilots
			4'h8: pl_nxt = 16'd8190;
			4'h9: pl_nxt = 16'd5490;
			4'ha: pl_nxt = 16'd4140;
			4'hb: pl_nxt = 16'd3330;
			// short, pilots on
			4'hc: pl_nxt = 16'd8370;
			4'hd: pl_nxt = 16'd5598;
			4'he: pl_nxt = 16'd4212;
			default: pl_nxt = 16'd3402;
		endcase
	end

	// one cycle behind the mode word
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			kbch_len <= '0;
			ts_len   <= '0;
			pl_len   <= '0;
		end else begin
			kbch_len <= kbch_nxt;
			ts_len   <= ts_nxt;
			pl_len   <= pl_nxt;
		end
	end

endmodule

//--- hdl/frame_phase_ctrl.sv
`timescale 1ns/1ns
`include "dvbs2_defines.svh"

module frame_phase_ctrl (
	input  logic                 sys_clk,
	input  logic                 glb_rst_n,
	input  logic                 fs_en,
	input  logic                 run_en,
	input  dvbs2_pkg::kbch_len_t kbch_len,
	input  dvbs2_pkg::kbch_len_t ts_len,
	input  dvbs2_pkg::pl_len_t   pl_len,
	output logic                 frame_start,
	output logic                 bb_frame_vld,
	output logic                 ts_rd_vld
);

	localparam int PAD_W = `DVBS2_PL_W - `DVBS2_KBCH_W;

	// symbol phase inside the current frame
	dvbs2_pkg::pl_len_t   phase_q;
	dvbs2_pkg::pl_len_t   phase_inc;
	// lengths frozen for the running frame
	dvbs2_pkg::pl_len_t   len_q;
	dvbs2_pkg::kbch_len_t kbch_q;
	dvbs2_pkg::kbch_len_t ts_q;
	logic                 run_q;
	logic                 run_rise;
	logic                 wrap;

	assign run_rise  = run_en & ~run_q;
	assign phase_inc = phase_q + dvbs2_pkg::pl_len_t'(1);
	// >= so a zero length wraps every tick and relatches
	assign wrap      = (phase_inc >= len_q);

	//////////////////////////////////////////////////////////////////////
	// phase accumulator and windows
	// windows are updated with the phase, so on every fs_en tick they
	// describe the phase that tick advances from
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			run_q        <= 1'b0;
			phase_q      <= '0;
			len_q        <= '0;
			kbch_q       <= '0;
			ts_q         <= '0;
			frame_start  <= 1'b0;
			bb_frame_vld <= 1'b0;
			ts_rd_vld    <= 1'b0;
		end else begin
			run_q       <= run_en;
			frame_start <= 1'b0;
			if (!run_en) begin
				// idle, parked at phase 0
				phase_q      <= '0;
				bb_frame_vld <= 1'b0;
				ts_rd_vld    <= 1'b0;
			end else if (run_rise || (fs_en && wrap)) begin
				// frame boundary, pick up the new mode here only
				phase_q      <= '0;
				len_q        <= pl_len;
				kbch_q       <= kbch_len;
				ts_q         <= ts_len;
				frame_start  <= ~run_rise;
				bb_frame_vld <= 1'b0;
				ts_rd_vld    <= 1'b0;
			end else if (fs_en) begin
				phase_q      <= phase_inc;
				// phase_inc is never 0 here, lower bound is implied
				bb_frame_vld <= (phase_inc <= {{PAD_W{1'b0}}, kbch_q});
				ts_rd_vld    <= (phase_inc <= {{PAD_W{1'b0}}, ts_q});
			end
		end
	end

	// boundary relatch must keep the phase inside the frozen frame
	ap_phase_in_frame: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		(len_q != '0) |-> (phase_q < len_q)
	);

endmodule

//--- hdl/ts_packet_source.sv
`timescale 1ns/1ns
`include "dvbs2_defines.svh"

module ts_packet_source (
	input  logic       sys_clk,
	input  logic       glb_rst_n,
	input  logic       fs_en,
	input  logic       ts_rd_vld,
	output logic [7:0] ts_byte,
	output logic       ts_valid,
	output logic       ts_head
);

	// byte position inside the 188 byte packet
	logic [7:0] byte_idx;
	// packet number, also the payload pattern
	logic [7:0] pkt_cnt;
	// one byte read this cycle
	logic       rd_fire;
	logic       pkt_last;

	assign rd_fire  = fs_en & ts_rd_vld;
	assign pkt_last = (byte_idx == (`DVBS2_TS_PKT_LEN - 8'd1));

	// packet position runs on across frame boundaries
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			byte_idx <= '0;
			pkt_cnt  <= '0;
			ts_byte  <= '0;
			ts_valid <= 1'b0;
			ts_head  <= 1'b0;
		end else begin
			ts_valid <= rd_fire;
			ts_head  <= rd_fire & (byte_idx == 8'd0);
			if (rd_fire) begin
				// sync byte first, then the packet number
				ts_byte <= (byte_idx == 8'd0) ? `DVBS2_TS_SYNC : pkt_cnt;
				if (pkt_last) begin
					byte_idx <= '0;
					pkt_cnt  <= pkt_cnt + 8'd1;
				end else begin
					byte_idx <= byte_idx + 8'd1;
				end
			end
		end
	end

	// a head flag always rides on a valid sync byte
	ap_head_is_sync: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		ts_head |-> (ts_valid && ts_byte == `DVBS2_TS_SYNC)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the frame timing testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f dvbs2_frame_timing.f \
	--top-module tb_dvbs2_frame_timing \
	-o tb_sim

sim_out=$(./obj_dir/tb_sim) || true
echo "$sim_out"

if grep -qx "Test completed successfully" <<< "$sim_out"; then
	exit 0
fi
exit 1

//--- tests/tb_mode_table.svh
`ifndef TB_MODE_TABLE_SVH
`define TB_MODE_TABLE_SVH

// columns: mode word {frame_short, pilot_on, modulation[1:0], ldpc_code[3:0]},
//          bch payload bytes, pl frame length in fs_en ticks
localparam int MODE_CNT = 12;

localparam logic [39:0] MODE_TBL [0:MODE_CNT-1] = '{
	// normal qpsk 1/4, no pilots
	{8'h00, 16'd2001, 16'd32490},
	// short 8psk 1/2, no pilots
	{8'h93, 16'd879, 16'd5490},
	// short 16apsk 2/3, pilots
	{8'he5, 16'd1329, 16'd4212},
	// short 32apsk 8/9, pilots
	{8'hf9, 16'd1779, 16'd3402},
	// normal 32apsk 9/10, no pilots
	{8'h3a, 16'd7274, 16'd13050},
	// normal 16apsk, code 11 does not exist
	{8'h2b, 16'd0, 16'd32490 - 16'd16200},
	// short qpsk, code 15 does not exist
	{8'h8f, 16'd0, 16'd8190},
	// short qpsk, code 10 only exists for normal frames
	{8'hca, 16'd0, 16'd8370},
	// normal 32apsk 3/5, pilots
	{8'h74, 16'd4836, 16'd13338},
	// short 16apsk 1/4, no pilots
	{8'ha0, 16'd384, 16'd4140},
	// normal 8psk 3/4, pilots
	{8'h56, 16'd6051, 16'd22194},
	// short 32apsk 5/6, no pilots
	{8'hb8, 16'd1644, 16'd3330}
};

`endif

//--- tests/tb_dvbs2_frame_timing.sv
`timescale 1ns/1ns
`include "dvbs2_defines.svh"

module tb_dvbs2_frame_timing;

	`include "tb_mode_table.svh"

	logic        sys_clk;
	logic        glb_rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pslverr;
	logic        fs_en;
	logic        frame_start;
	logic        bb_frame_vld;
	logic [7:0]  ts_byte;
	logic        ts_valid;
	logic        ts_head;

	logic [31:0] rng_state;
	int          err_cnt;
	int          chk_cnt;
	// running counts inside the current frame
	int          tick_cnt;
	int          bb_cnt;
	int          ts_cnt;
	// counts of the frame that just ended
	int          rec_ticks;
	int          rec_bb;
	int          rec_ts;
	int          frames_seen;
	// expected position in the ts stream
	int          ts_idx;
	int          ts_pkt;

	dvbs2_frame_timing_top dut0 (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pslverr      (pslverr),
		.fs_en        (fs_en),
		.frame_start  (frame_start),
		.bb_frame_vld (bb_frame_vld),
		.ts_byte      (ts_byte),
		.ts_valid     (ts_valid),
		.ts_head      (ts_head)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// fs_en high about every other cycle
	initial begin
		rng_state = 32'hc9dcc005;
		fs_en = 1'b0;
		forever begin
			@(posedge sys_clk);
			#1;
			rng_state = xorshift32(rng_state);
			fs_en = rng_state[16];
		end
	end

	task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		chk_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// apb master, setup then access, no wait states
	//////////////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge sys_clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		// response is valid in the access cycle
		@(negedge sys_clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge sys_clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
		input logic exp_err, input string what);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, addr, wdata, rdata, err);
		check_val(32'(err), 32'(exp_err), what);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
		output logic err);
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	// returns once the monitor has closed the running frame
	task automatic wait_frame();
		int seen_before;
		seen_before = frames_seen;
		wait (frames_seen != seen_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitor, sampled mid cycle where everything is settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge sys_clk) begin
		if (glb_rst_n === 1'b1) begin
			// frame runs from one frame_start cycle up to the next
			if (frame_start) begin
				rec_ticks = tick_cnt;
				rec_bb    = bb_cnt;
				rec_ts    = ts_cnt;
				tick_cnt  = 0;
				bb_cnt    = 0;
				ts_cnt    = 0;
				frames_seen++;
			end
			if (fs_en) tick_cnt++;
			if (fs_en && bb_frame_vld) bb_cnt++;
			// packet framing runs on across frames
			if (ts_valid) begin
				ts_cnt++;
				if (ts_idx == 0) begin
					check_val(32'(ts_head), 32'd1, "ts_head on byte 0");
					check_val(32'(ts_byte), 32'(`DVBS2_TS_SYNC), "sync byte");
				end else begin
					check_val(32'(ts_head), 32'd0, "ts_head inside packet");
					check_val(32'(ts_byte), 32'(ts_pkt % 256), "payload byte");
				end
				ts_idx++;
				if (ts_idx == 32'(`DVBS2_TS_PKT_LEN)) begin
					ts_idx = 0;
					ts_pkt++;
				end
			end else begin
				check_val(32'(ts_head), 32'd0, "ts_head without ts_valid");
			end
		end
	end

	initial begin
		logic [31:0]           rd;
		logic                  err;
		int                    exp_kbch;
		int                    exp_pl;
		int                    exp_ts;
		int                    prev_kbch;
		int                    prev_pl;
		dvbs2_pkg::mode_word_u mw;
		glb_rst_n = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = 4'h0;
		pwdata    = 32'd0;
		repeat (16) @(posedge sys_clk);
		#1 glb_rst_n = 1'b1;

		// start in the first mode, frame opened by run_en holds idle ticks
		apb_write(`DVBS2_REG_MODE, 32'(MODE_TBL[0][39:32]), 1'b0, "first mode write");
		apb_write(`DVBS2_REG_CTRL, 32'd1, 1'b0, "run enable write");
		wait_frame();
		prev_kbch = int'(MODE_TBL[0][31:16]);
		prev_pl   = int'(MODE_TBL[0][15:0]);

		for (int i = 0; i < MODE_CNT; i++) begin
			mw       = MODE_TBL[i][39:32];
			exp_kbch = int'(MODE_TBL[i][31:16]);
			exp_pl   = int'(MODE_TBL[i][15:0]);
			exp_ts   = (exp_kbch == 0) ? 0 : exp_kbch - `DVBS2_BBHDR_BYTES;
			$display("mode %h: %s frame, pl key %h, ldpc code %0d", mw,
				mw.fec_view.frame_short ? "short" : "normal",
				mw.pl_view.pl_key, mw.fec_view.ldpc_code);
			// write lands well inside the running frame
			repeat (40) @(posedge sys_clk);
			apb_write(`DVBS2_REG_MODE, {24'd0, mw}, 1'b0, "mode write");
			wait_frame();
			check_val(rec_ticks, prev_pl, "ticks of frame holding the mode write");
			check_val(rec_bb, prev_kbch, "bb window of frame holding the mode write");
			wait_frame();
			check_val(rec_ticks, exp_pl, "pl frame ticks");
			check_val(rec_bb, exp_kbch, "bb window ticks");
			check_val(rec_ts, exp_ts, "ts bytes per frame");
			prev_kbch = exp_kbch;
			prev_pl   = exp_pl;
		end

		// register checks right after a boundary, far from the next one
		wait_frame();
		apb_read(`DVBS2_REG_FCNT, rd, err);
		check_val(rd, frames_seen, "frame count read");
		check_val(32'(err), 32'd0, "pslverr on frame count read");
		apb_write(`DVBS2_REG_FCNT, 32'd5, 1'b1, "pslverr on frame count write");
		apb_read(`DVBS2_REG_FCNT, rd, err);
		check_val(rd, frames_seen, "frame count after rejected write");
		apb_write(4'hc, 32'd1, 1'b1, "pslverr on unmapped write");
		apb_read(4'hc, rd, err);
		check_val(32'(err), 32'd1, "pslverr on unmapped read");
		apb_read(`DVBS2_REG_MODE, rd, err);
		check_val(rd, 32'(MODE_TBL[MODE_CNT-1][39:32]), "mode register read back");
		// stop clears the frame count
		apb_write(`DVBS2_REG_CTRL, 32'd0, 1'b0, "run disable write");
		apb_read(`DVBS2_REG_FCNT, rd, err);
		check_val(rd, 32'd0, "frame count after stop");

		$display("checks run %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// two frames per mode at about half rate fs_en, plus start and apb time
	initial begin
		longint wd_cycles;
		int     i;
		wd_cycles = 0;
		for (i = 0; i < MODE_CNT; i++) begin
			wd_cycles += 2 * longint'(MODE_TBL[i][15:0]);
		end
		wd_cycles = wd_cycles * 4 + 20000;
		#(wd_cycles * 10);
		$display("timeout: run did not finish within %0d clock cycles", wd_cycles);
		$display("Test failed");
		$finish;
	end

endmodule
